// ==== design/eth_crc32.sv ====
`timescale 1ns/100ps

module eth_crc32 (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        clear_i,
    input  logic        en_i,
    input  logic [7:0]  data_i,
    output logic [31:0] crc_o
);

    localparam logic [31:0] POLY = 32'hedb88320;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // lsb first, one bit per step
    always_comb begin
        crc_next = crc_q ^ {24'h000000, data_i};
        for (int i = 0; i < 8; i++) begin
            crc_next = crc_next[0] ? ((crc_next >> 1) ^ POLY) : (crc_next >> 1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    assign crc_o = ~crc_q;

endmodule

// ==== design/gmii_frame_serializer.sv ====
`timescale 1ns/100ps

module gmii_frame_serializer (
    input  logic              clk_i,
    input  logic              rst_i,

    hdr_stage_if.serializer   hdr,

    output logic              pop_o,
    input  logic [7:0]        pop_data_i,

    output logic              tx_en_o,
    output logic [7:0]        tx_d_o
);
    import udp_tx_pkg::*;

    localparam int HDR_W     = $bits(eth_header_t);
    // payload bytes below this count get zero padding
    localparam int PAD_LIMIT = MIN_BODY_BYTES - HEADER_BYTES;

    // state and cnt describe the byte now on the wire
    tx_state_t          state;
    tx_state_t          state_n;
    logic [10:0]        cnt;
    logic [10:0]        cnt_n;
    logic               en_n;
    logic [7:0]         d_n;

    logic [HDR_W-1:0]   hdr_sr;
    payload_len_t       len_q;
    payload_len_t       pop_left;
    logic [1:0]         fcs_idx;
    logic               crc_clear;
    logic               crc_en;
    logic [31:0]        crc;

    assign hdr.taken = (state == IDLE) && hdr.valid;

    assign fcs_idx = cnt[1:0] + 2'd1;

    always_comb begin
        state_n = state;
        cnt_n   = cnt + 11'd1;
        en_n    = 1'b1;
        d_n     = 8'h00;
        case (state)
            IDLE: begin
                cnt_n = '0;
                en_n  = 1'b0;
                if (hdr.valid) begin
                    state_n = PREAMBLE;
                    en_n    = 1'b1;
                    d_n     = PREAMBLE_BYTE;
                end
            end
            PREAMBLE: begin
                if (cnt == 11'(PREAMBLE_BYTES - 1)) begin
                    state_n = SFD;
                    cnt_n   = '0;
                    d_n     = SFD_BYTE;
                end else begin
                    d_n = PREAMBLE_BYTE;
                end
            end
            SFD: begin
                state_n = HEADER;
                cnt_n   = '0;
                d_n     = hdr_sr[HDR_W-1 -: 8];
            end
            HEADER: begin
                if (cnt == 11'(HEADER_BYTES - 1)) begin
                    state_n = PAYLOAD;
                    cnt_n   = '0;
                    d_n     = pop_data_i;
                end else begin
                    d_n = hdr_sr[HDR_W-1 -: 8];
                end
            end
            PAYLOAD: begin
                if (cnt == len_q - 11'd1) begin
                    if (len_q < PAD_LIMIT) begin
                        // cnt keeps counting through the pad
                        state_n = PAD;
                    end else begin
                        state_n = FCS;
                        cnt_n   = '0;
                        d_n     = crc[7:0];
                    end
                end else begin
                    d_n = pop_data_i;
                end
            end
            PAD: begin
                if (cnt == 11'(PAD_LIMIT - 1)) begin
                    state_n = FCS;
                    cnt_n   = '0;
                    d_n     = crc[7:0];
                end
            end
            FCS: begin
                if (cnt == 11'(FCS_BYTES - 1)) begin
                    state_n = GAP;
                    cnt_n   = '0;
                    en_n    = 1'b0;
                end else begin
                    d_n = crc[{fcs_idx, 3'b000} +: 8];
                end
            end
            GAP: begin
                en_n = 1'b0;
                if (cnt == 11'(IFG_BYTES - 1)) begin
                    state_n = IDLE;
                    cnt_n   = '0;
                end
            end
            default: begin
                state_n = IDLE;
                cnt_n   = '0;
                en_n    = 1'b0;
            end
        endcase
    end

    // pops run one byte ahead of the wire
    assign pop_o = (pop_left != '0) &&
                   ((state == PAYLOAD) ||
                    ((state == HEADER) && (cnt >= 11'(HEADER_BYTES - 2))));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state    <= IDLE;
            cnt      <= '0;
            tx_en_o  <= 1'b0;
            pop_left <= '0;
        end else begin
            state   <= state_n;
            cnt     <= cnt_n;
            tx_en_o <= en_n;
            if (hdr.taken) begin
                pop_left <= hdr.len;
            end else if (pop_o) begin
                pop_left <= pop_left - 11'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        tx_d_o <= d_n;
        if (hdr.taken) begin
            hdr_sr <= hdr.header;
            len_q  <= hdr.len;
        end else if (state_n == HEADER) begin
            hdr_sr <= hdr_sr << 8;
        end
    end

    // fed at the same edge the byte is registered
    assign crc_clear = state == IDLE;
    assign crc_en    = en_n && ((state_n == HEADER) || (state_n == PAYLOAD) ||
                                (state_n == PAD));

    eth_crc32 i_crc (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .clear_i(crc_clear),
        .en_i   (crc_en),
        .data_i (d_n),
        .crc_o  (crc)
    );

endmodule

// ==== design/hdr_stage_if.sv ====
`timescale 1ns/100ps

interface hdr_stage_if;
    import udp_tx_pkg::*;

    logic         valid;
    eth_header_t  header;
    payload_len_t len;
    // strobe, serializer leaves IDLE
    logic         taken;

    modport builder (
        output valid,
        output header,
        output len,
        input  taken
    );

    modport serializer (
        input  valid,
        input  header,
        input  len,
        output taken
    );

endinterface

// ==== design/payload_buffer.sv ====
`timescale 1ns/100ps

module payload_buffer #(
    parameter int FIFO_DEPTH      = 2048,
    parameter int LEN_QUEUE_DEPTH = 4,
    parameter int MAX_PAYLOAD     = 1472
) (
    input  logic                     clk_i,
    input  logic                     rst_i,

    input  logic                     s_valid_i,
    input  logic [7:0]               s_data_i,
    input  logic                     s_last_i,
    input  udp_tx_pkg::payload_len_t s_len_i,
    output logic                     s_ready_o,

    output logic                     len_avail_o,
    output udp_tx_pkg::payload_len_t len_head_o,
    input  logic                     len_pop_i,

    input  logic                     pop_i,
    output logic [7:0]               pop_data_o
);
    import udp_tx_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = AW + 1;
    localparam int QW = (LEN_QUEUE_DEPTH > 1) ? $clog2(LEN_QUEUE_DEPTH) : 1;

    logic [7:0]    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // bytes reserved by admitted frames and not yet popped
    logic [CW-1:0] used;
    logic [CW-1:0] used_n;
    logic [CW:0]   need;

    payload_len_t  lq_mem [LEN_QUEUE_DEPTH];
    logic [QW-1:0] lq_wr;
    logic [QW-1:0] lq_rd;
    logic [QW:0]   lq_count;

    logic mid_frame;
    logic dropping;
    logic len_bad;
    logic fits;
    logic q_space;
    logic first_ok;
    logic hs;
    logic first_hs;
    logic admit;
    logic wr_en;
    logic push_len;

    assign len_bad  = (s_len_i == '0) || (s_len_i > MAX_PAYLOAD);
    assign need     = {1'b0, used} + (CW+1)'(s_len_i);
    assign fits     = need <= (CW+1)'(FIFO_DEPTH);
    assign q_space  = lq_count < (QW+1)'(LEN_QUEUE_DEPTH);
    // bad lengths are swallowed without needing space
    assign first_ok = len_bad || (fits && q_space);

    assign s_ready_o = mid_frame || (s_valid_i && first_ok);

    assign hs       = s_valid_i && s_ready_o;
    assign first_hs = hs && !mid_frame;
    assign admit    = first_hs && !len_bad;
    assign wr_en    = admit || (hs && mid_frame && !dropping);
    assign push_len = hs && s_last_i && (first_hs ? !len_bad : !dropping);

    always_comb begin
        used_n = used;
        if (admit) begin
            used_n = used_n + CW'(s_len_i);
        end
        if (pop_i) begin
            used_n = used_n - CW'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mid_frame <= 1'b0;
            dropping  <= 1'b0;
            used      <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
        end else begin
            used <= used_n;
            if (hs) begin
                mid_frame <= !s_last_i;
            end
            if (first_hs) begin
                dropping <= len_bad;
            end
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= s_data_i;
        end
        if (pop_i) begin
            pop_data_o <= mem[rd_ptr];
        end
    end

    // length queue, written when the last byte is accepted
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lq_wr    <= '0;
            lq_rd    <= '0;
            lq_count <= '0;
        end else begin
            if (push_len) begin
                lq_wr <= (lq_wr == QW'(LEN_QUEUE_DEPTH - 1)) ? '0 : lq_wr + QW'(1);
            end
            if (len_pop_i) begin
                lq_rd <= (lq_rd == QW'(LEN_QUEUE_DEPTH - 1)) ? '0 : lq_rd + QW'(1);
            end
            lq_count <= lq_count + (QW+1)'(push_len) - (QW+1)'(len_pop_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_len) begin
            lq_mem[lq_wr] <= s_len_i;
        end
    end

    assign len_avail_o = lq_count != '0;
    assign len_head_o  = lq_mem[lq_rd];

endmodule

// ==== design/udp_header_builder.sv ====
`timescale 1ns/100ps

module udp_header_builder (
    input  logic                     clk_i,
    input  logic                     rst_i,

    input  logic [47:0]              fpga_mac_i,
    input  logic [31:0]              fpga_ip_i,
    input  logic [15:0]              fpga_port_i,
    input  logic [47:0]              host_mac_i,
    input  logic [31:0]              host_ip_i,
    input  logic [15:0]              host_port_i,

    input  logic                     len_avail_i,
    input  udp_tx_pkg::payload_len_t len_head_i,
    output logic                     len_pop_o,

    hdr_stage_if.builder             hdr
);
    import udp_tx_pkg::*;

    localparam logic [7:0] IP_VER_IHL = 8'h45;
    localparam int         IP_LSB     = UDP_HDR_BYTES * 8;
    localparam int         IP_W       = IP_HDR_BYTES * 8;

    payload_len_t    len_q;
    eth_header_t     hdr_comb;
    eth_header_t     hdr_final;
    logic [IP_W-1:0] ip_words;
    logic [19:0]     sum_comb;
    logic [19:0]     sum_q;
    logic [16:0]     fold_a;
    logic [15:0]     fold_q;
    // one-hot step: length latched, sum done, fold done
    logic [2:0]      step;
    logic            busy;

    assign busy      = (|step) || hdr.valid;
    assign len_pop_o = len_avail_i && !busy;

    always_comb begin
        hdr_comb.dst_mac       = host_mac_i;
        hdr_comb.src_mac       = fpga_mac_i;
        hdr_comb.ethertype     = ETHERTYPE_IPV4;
        hdr_comb.ip_ver_ihl    = IP_VER_IHL;
        hdr_comb.ip_tos        = 8'h00;
        hdr_comb.ip_total_len  = 16'(len_q) + 16'(IP_HDR_BYTES + UDP_HDR_BYTES);
        hdr_comb.ip_ident      = 16'h0000;
        hdr_comb.ip_flags_frag = IP_FLAGS_DF;
        hdr_comb.ip_ttl        = IP_TTL;
        hdr_comb.ip_protocol   = IP_PROTO_UDP;
        hdr_comb.ip_checksum   = 16'h0000;
        hdr_comb.src_ip        = fpga_ip_i;
        hdr_comb.dst_ip        = host_ip_i;
        hdr_comb.src_port      = fpga_port_i;
        hdr_comb.dst_port      = host_port_i;
        hdr_comb.udp_len       = 16'(len_q) + 16'(UDP_HDR_BYTES);
        // zero udp checksum, allowed over ipv4
        hdr_comb.udp_checksum  = 16'h0000;
    end

    assign ip_words = hdr_comb[IP_LSB +: IP_W];

    // ten 16-bit words with the checksum field zero
    always_comb begin
        sum_comb = '0;
        for (int i = 0; i < IP_HDR_BYTES / 2; i++) begin
            sum_comb = sum_comb + 20'(ip_words[i*16 +: 16]);
        end
    end

    assign fold_a = {1'b0, sum_q[15:0]} + {13'b0, sum_q[19:16]};

    always_comb begin
        hdr_final             = hdr_comb;
        hdr_final.ip_checksum = ~fold_q;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            step      <= '0;
            hdr.valid <= 1'b0;
        end else begin
            step <= {step[1:0], len_pop_o};
            if (step[2]) begin
                hdr.valid <= 1'b1;
            end else if (hdr.taken) begin
                hdr.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (len_pop_o) begin
            len_q <= len_head_i;
        end
        if (step[0]) begin
            sum_q <= sum_comb;
        end
        if (step[1]) begin
            fold_q <= fold_a[15:0] + {15'b0, fold_a[16]};
        end
        if (step[2]) begin
            hdr.header <= hdr_final;
            hdr.len    <= len_q;
        end
    end

endmodule

// ==== design/udp_tx_pkg.sv ====
package udp_tx_pkg;

    // payload length in bytes, up to 1472
    typedef logic [10:0] payload_len_t;

    // 42 header bytes, first field goes out first
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
        logic [7:0]  ip_ver_ihl;
        logic [7:0]  ip_tos;
        logic [15:0] ip_total_len;
        logic [15:0] ip_ident;
        logic [15:0] ip_flags_frag;
        logic [7:0]  ip_ttl;
        logic [7:0]  ip_protocol;
        logic [15:0] ip_checksum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] udp_len;
        logic [15:0] udp_checksum;
    } eth_header_t;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        HEADER,
        PAYLOAD,
        PAD,
        FCS,
        GAP
    } tx_state_t;

    localparam int          PREAMBLE_BYTES = 7;
    localparam logic [7:0]  PREAMBLE_BYTE  = 8'h55;
    localparam logic [7:0]  SFD_BYTE       = 8'hd5;
    localparam int          HEADER_BYTES   = 42;
    // bytes between SFD and FCS at minimum frame size
    localparam int          MIN_BODY_BYTES = 60;
    localparam int          FCS_BYTES      = 4;
    localparam int          IFG_BYTES      = 12;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTO_UDP   = 8'd17;
    localparam logic [7:0]  IP_TTL         = 8'd64;
    localparam logic [15:0] IP_FLAGS_DF    = 16'h4000;
    localparam int          IP_HDR_BYTES   = 20;
    localparam int          UDP_HDR_BYTES  = 8;

endpackage

// ==== design/udp_tx_top.sv ====
`timescale 1ns/100ps

module udp_tx_top #(
    parameter int FIFO_DEPTH      = 2048,
    parameter int LEN_QUEUE_DEPTH = 4,
    parameter int MAX_PAYLOAD     = 1472
) (
    input  logic                     clk_i,
    input  logic                     rst_i,

    input  logic                     s_valid_i,
    input  logic [7:0]               s_data_i,
    input  logic                     s_last_i,
    input  udp_tx_pkg::payload_len_t s_len_i,
    output logic                     s_ready_o,

    input  logic [47:0]              fpga_mac_i,
    input  logic [31:0]              fpga_ip_i,
    input  logic [15:0]              fpga_port_i,
    input  logic [47:0]              host_mac_i,
    input  logic [31:0]              host_ip_i,
    input  logic [15:0]              host_port_i,

    output logic                     tx_en_o,
    output logic [7:0]               tx_d_o
);
    import udp_tx_pkg::*;

    logic         len_avail;
    payload_len_t len_head;
    logic         len_pop;
    logic         pop;
    logic [7:0]   pop_data;

    hdr_stage_if hdr_link ();

    payload_buffer #(
        .FIFO_DEPTH     (FIFO_DEPTH),
        .LEN_QUEUE_DEPTH(LEN_QUEUE_DEPTH),
        .MAX_PAYLOAD    (MAX_PAYLOAD)
    ) i_payload_buffer (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .s_valid_i  (s_valid_i),
        .s_data_i   (s_data_i),
        .s_last_i   (s_last_i),
        .s_len_i    (s_len_i),
        .s_ready_o  (s_ready_o),
        .len_avail_o(len_avail),
        .len_head_o (len_head),
        .len_pop_i  (len_pop),
        .pop_i      (pop),
        .pop_data_o (pop_data)
    );

    udp_header_builder i_header_builder (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fpga_mac_i (fpga_mac_i),
        .fpga_ip_i  (fpga_ip_i),
        .fpga_port_i(fpga_port_i),
        .host_mac_i (host_mac_i),
        .host_ip_i  (host_ip_i),
        .host_port_i(host_port_i),
        .len_avail_i(len_avail),
        .len_head_i (len_head),
        .len_pop_o  (len_pop),
        .hdr        (hdr_link.builder)
    );

    gmii_frame_serializer i_serializer (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .hdr       (hdr_link.serializer),
        .pop_o     (pop),
        .pop_data_i(pop_data),
        .tx_en_o   (tx_en_o),
        .tx_d_o    (tx_d_o)
    );

endmodule

// ==== project.f ====
design/udp_tx_pkg.sv
design/hdr_stage_if.sv
design/eth_crc32.sv
design/payload_buffer.sv
design/udp_header_builder.sv
design/gmii_frame_serializer.sv
design/udp_tx_top.sv
sim/tb_clock_gen.sv
sim/udp_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the UDP transmitter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module udp_tx_tb -o udp_tx_sim \
    && ./obj_dir/udp_tx_sim | tee /dev/stderr | grep -q "^TESTBENCH PASSED$" \
    && echo "simulation ok" \
    || { echo "simulation did not pass"; exit 1; }

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release lines up with the stimulus delay
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10 rst_o = 1'b0;
    end

endmodule

// ==== sim/udp_tx_tb.sv ====
`timescale 1ns/100ps

module udp_tx_tb;
    import udp_tx_pkg::*;

    localparam int          MAX_PAYLOAD = 1472;
    localparam int          NUM_ENTRIES = 16;
    localparam logic [47:0] FPGA_MAC    = 48'h02_00_5e_10_20_30;
    localparam logic [31:0] FPGA_IP     = 32'hc0a8_010a;
    localparam logic [15:0] FPGA_PORT   = 16'd1234;
    localparam logic [47:0] HOST_MAC    = 48'h00_1b_21_3a_4c_5d;

    typedef struct packed {
        payload_len_t len;
        logic         idle;
        logic [31:0]  host_ip;
        logic [15:0]  host_port;
    } entry_t;

    logic         clk;
    logic         rst;
    logic         s_valid;
    logic [7:0]   s_data;
    logic         s_last;
    payload_len_t s_len;
    logic         s_ready;
    logic [31:0]  host_ip;
    logic [15:0]  host_port;
    logic         tx_en;
    logic [7:0]   tx_d;

    entry_t     tests [NUM_ENTRIES];
    logic [7:0] pay [2048];
    logic [7:0] exp_bytes [$];
    int         exp_lens [$];

    int byte_errs;
    int len_errs;
    int gap_errs;
    int other_errs;
    int stall_cycles;
    int cycles;
    int cycle_limit = 200000;
    int seen_frames;
    int mon_count;
    int gap_cnt;
    logic in_frame;

    tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(3)) i_clk_gen (.clk_o(clk), .rst_o(rst));

    udp_tx_top #(
        .FIFO_DEPTH     (2048),
        .LEN_QUEUE_DEPTH(4),
        .MAX_PAYLOAD    (MAX_PAYLOAD)
    ) uut (
        .clk_i      (clk),
        .rst_i      (rst),
        .s_valid_i  (s_valid),
        .s_data_i   (s_data),
        .s_last_i   (s_last),
        .s_len_i    (s_len),
        .s_ready_o  (s_ready),
        .fpga_mac_i (FPGA_MAC),
        .fpga_ip_i  (FPGA_IP),
        .fpga_port_i(FPGA_PORT),
        .host_mac_i (HOST_MAC),
        .host_ip_i  (host_ip),
        .host_port_i(host_port),
        .tx_en_o    (tx_en),
        .tx_d_o     (tx_d)
    );

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int pos);
        if (got !== exp) begin
            byte_errs++;
            $display("ERR %0t ns: frame %0d byte %0d is %02h, expected %02h",
                     $time, seen_frames, pos, got, exp);
        end
    endtask

    task automatic check_len(input payload_len_t got, input payload_len_t exp);
        if (got !== exp) begin
            len_errs++;
            $display("ERR %0t ns: frame %0d has %0d bytes, expected %0d",
                     $time, seen_frames, got, exp);
        end
    endtask

    task automatic check_gap(input int low_cycles);
        if (low_cycles < IFG_BYTES) begin
            gap_errs++;
            $display("ERR %0t ns: gap before frame %0d is %0d cycles, expected at least %0d",
                     $time, seen_frames, low_cycles, IFG_BYTES);
        end
    endtask

    function automatic logic len_ok(input payload_len_t len);
        return (len != 0) && (len <= MAX_PAYLOAD);
    endfunction

    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'h000000, b};
        for (int k = 0; k < 8; k++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
        end
        return c;
    endfunction

    // wire image of one frame from pay[] and the current host settings
    function automatic void add_expected(input payload_len_t len);
        logic [335:0] h;
        logic [31:0]  sum;
        logic [31:0]  crc;
        logic [7:0]   b;
        int           body;
        h = {HOST_MAC, FPGA_MAC, 16'h0800, 8'h45, 8'h00, 16'(len) + 16'd28, 16'h0000,
             16'h4000, 8'd64, 8'd17, 16'h0000, FPGA_IP, host_ip, FPGA_PORT, host_port,
             16'(len) + 16'd8, 16'h0000};
        sum = 0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 32'(h[335 - 8 * (14 + 2 * i) -: 16]);
        end
        sum = (sum & 32'hffff) + (sum >> 16);
        sum = (sum & 32'hffff) + (sum >> 16);
        h[335 - 8 * 24 -: 16] = ~sum[15:0];
        for (int i = 0; i < 7; i++) begin
            exp_bytes.push_back(8'h55);
        end
        exp_bytes.push_back(8'hd5);
        crc = 32'hffffffff;
        body = 0;
        for (int i = 0; i < 42 + int'(len) || body < 60; i++) begin
            if (i < 42) begin
                b = h[335 - 8 * i -: 8];
            end else if (i < 42 + int'(len)) begin
                b = pay[i - 42];
            end else begin
                b = 8'h00;
            end
            exp_bytes.push_back(b);
            crc = crc_byte(crc, b);
            body++;
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            exp_bytes.push_back(crc[8 * i +: 8]);
        end
        exp_lens.push_back(8 + body + 4);
    endfunction

    function automatic int run_limit();
        int total;
        int len;
        total = 500;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            len = int'(tests[e].len);
            total += ((len == 0) ? 4 : len) + 20;
            if (len_ok(tests[e].len)) begin
                total += 8 + 42 + ((len < 18) ? 18 : len) + 4 + IFG_BYTES + 4;
            end
            if (tests[e].idle) begin
                total += 30;
            end
        end
        return total;
    endfunction

    task automatic send_frame(input payload_len_t len, input int n);
        int   i;
        logic rdy;
        i = 0;
        while (i < n) begin
            s_valid = 1'b1;
            s_data  = pay[i];
            s_last  = (i == n - 1);
            s_len   = len;
            @(negedge clk);
            rdy = s_ready;
            if (!rdy) begin
                stall_cycles++;
            end
            @(posedge clk);
            #10;
            if (rdy) begin
                i++;
            end
        end
        s_valid = 1'b0;
        s_last  = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_lens.size() != 0 || in_frame) begin
            @(posedge clk);
        end
        repeat (IFG_BYTES + 4) @(posedge clk);
        #10;
    endtask

    task automatic load_tests();
        tests[0]  = '{11'd100,  1'b1, 32'hc0a8_0164, 16'd5000};
        tests[1]  = '{11'd1,    1'b0, 32'hc0a8_0164, 16'd5000};
        tests[2]  = '{11'd17,   1'b0, 32'hc0a8_0164, 16'd5000};
        tests[3]  = '{11'd18,   1'b0, 32'hc0a8_0164, 16'd5000};
        tests[4]  = '{11'd0,    1'b0, 32'hc0a8_0164, 16'd5000};
        tests[5]  = '{11'd1473, 1'b0, 32'hc0a8_0164, 16'd5000};
        tests[6]  = '{11'd46,   1'b0, 32'hc0a8_0164, 16'd5000};
        // long frames back to back fill the FIFO
        tests[7]  = '{11'd1472, 1'b1, 32'hc0a8_0165, 16'd6001};
        tests[8]  = '{11'd1472, 1'b0, 32'hc0a8_0165, 16'd6001};
        // short ones pile up in the length queue
        for (int e = 9; e < 15; e++) begin
            tests[e] = '{11'd30, 1'b0, 32'hc0a8_0165, 16'd6001};
        end
        tests[15] = '{11'd64,   1'b1, 32'h0a00_0002, 16'd7002};
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles with %0d frames still expected",
                     cycles, exp_lens.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // frame monitor
    always @(negedge clk) begin
        if (!rst) begin
            if (tx_en) begin
                if (!in_frame) begin
                    in_frame  = 1'b1;
                    mon_count = 0;
                    if (seen_frames > 0) begin
                        check_gap(gap_cnt);
                    end
                end
                if (exp_bytes.size() == 0) begin
                    other_errs++;
                    $display("unexpected byte %02h on the wire at %0t ns", tx_d, $time);
                end else begin
                    check_byte(tx_d, exp_bytes.pop_front(), mon_count);
                end
                mon_count++;
            end else if (in_frame) begin
                in_frame = 1'b0;
                gap_cnt  = 1;
                if (exp_lens.size() == 0) begin
                    other_errs++;
                    $display("frame %0d was sent but none was expected", seen_frames);
                end else begin
                    check_len(payload_len_t'(mon_count), payload_len_t'(exp_lens.pop_front()));
                end
                seen_frames++;
            end else begin
                gap_cnt++;
            end
        end
    end

    initial begin
        int n;
        int total_errs;
        s_valid     = 1'b0;
        s_data      = 8'h00;
        s_last      = 1'b0;
        s_len       = '0;
        host_ip     = 32'h0;
        host_port   = 16'h0;
        in_frame    = 1'b0;
        cycles      = 0;
        seen_frames = 0;
        gap_cnt     = 0;
        mon_count   = 0;
        void'($urandom(32'haa25_80ef));
        load_tests();
        cycle_limit = run_limit();
        @(negedge rst);
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            if (tests[e].idle) begin
                wait_drain();
                host_ip   = tests[e].host_ip;
                host_port = tests[e].host_port;
            end
            n = (tests[e].len == 0) ? 4 : int'(tests[e].len);
            for (int i = 0; i < n; i++) begin
                pay[i] = 8'($urandom);
            end
            if (len_ok(tests[e].len)) begin
                add_expected(tests[e].len);
            end
            send_frame(tests[e].len, n);
        end
        wait_drain();
        repeat (50) @(posedge clk);
        if (stall_cycles == 0) begin
            other_errs++;
            $display("s_ready_o never went low while the buffer was full");
        end
        total_errs = byte_errs + len_errs + gap_errs + other_errs;
        $display("frames %0d, errors: byte %0d, length %0d, gap %0d, other %0d",
                 seen_frames, byte_errs, len_errs, gap_errs, other_errs);
        if (total_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
